/* eu_issue_arbiter.sv */
// Issue arbiter toward the execution unit
// Round-robin among ready collectors with grant lock under back-pressure

`timescale 1ns/100ps

module eu_issue_arbiter
    import gpu_inst_pkg::*;
#(
    parameter int unsigned NumCollectors = 4
) (
    input  logic clk_i,
    input  logic arst_n_i,

    // Collector side
    input  logic        [NumCollectors-1:0] col_valid_i,
    input  issue_inst_t [NumCollectors-1:0] col_inst_i,
    output logic        [NumCollectors-1:0] col_ready_o,

    // Execution unit port
    output logic        eu_valid_o,
    output issue_inst_t eu_inst_o,
    input  logic        eu_ready_i
);

    localparam int unsigned IdxWidth = (NumCollectors > 1) ? $clog2(NumCollectors) : 1;
    typedef logic [IdxWidth-1:0] col_idx_t;

    // Search start
    col_idx_t ptr_q;
    // Grant held while the unit stalls
    logic     lock_q;
    col_idx_t lock_idx_q;
    // Current choice
    col_idx_t grant;
    logic     found;

    always_comb begin
        col_idx_t cand;
        found = 1'b0;
        grant = ptr_q;
        for (int k = 0; k < NumCollectors; k++) begin
            cand = col_idx_t'((int'(ptr_q) + k) % NumCollectors);
            if (!found && col_valid_i[cand]) begin
                found = 1'b1;
                grant = cand;
            end
        end
        // Stalled transfer keeps its collector
        if (lock_q) begin
            grant = lock_idx_q;
            found = col_valid_i[lock_idx_q];
        end
        col_ready_o        = '0;
        col_ready_o[grant] = found && eu_ready_i;
    end

    assign eu_valid_o = found;
    assign eu_inst_o  = col_inst_i[grant];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q      <= '0;
            lock_q     <= 1'b0;
            lock_idx_q <= '0;
        end else begin
            lock_q     <= eu_valid_o && !eu_ready_i;
            lock_idx_q <= grant;
            // Advance only after a transfer
            if (eu_valid_o && eu_ready_i) begin
                ptr_q <= col_idx_t'((int'(grant) + 1) % NumCollectors);
            end
        end
    end

endmodule

/* files.f */
gpu_cfg_pkg.sv
gpu_inst_pkg.sv
operand_collector.sv
opc_dispatch_router.sv
rf_read_arbiter.sv
register_file.sv
eu_issue_arbiter.sv
opc_cluster_top.sv
tb_opc_cluster.sv

/* gpu_cfg_pkg.sv */
// Compute unit dimensions
// Vector typedefs for warp ids, tags, registers and data

package gpu_cfg_pkg;

    // ####################
    // Unit dimensions
    // ####################

    // Warps per compute unit
    localparam int unsigned NumWarps = 8;
    // Threads per warp and active mask width
    localparam int unsigned WarpWidth = 8;
    // Registers visible to each warp
    localparam int unsigned NumRegs = 16;
    // Bits per register
    localparam int unsigned RegWidth = 32;
    // In-flight tags per warp
    localparam int unsigned NumTags = 4;
    // Source operands per instruction
    localparam int unsigned OperandsPerInst = 2;
    // Program counter width
    localparam int unsigned PcWidth = 32;

    // Derived field widths
    localparam int unsigned WidWidth    = $clog2(NumWarps);
    localparam int unsigned TagWidth    = $clog2(NumTags);
    localparam int unsigned RegIdxWidth = $clog2(NumRegs);

    // ####################
    // Typed vectors
    // ####################

    typedef logic [WidWidth-1:0]    wid_t;
    typedef logic [TagWidth-1:0]    tag_t;
    // Tag in the upper bits, warp id in the lower bits
    typedef logic [TagWidth+WidWidth-1:0] iid_t;
    typedef logic [RegIdxWidth-1:0] reg_idx_t;
    typedef logic [PcWidth-1:0]     pc_t;
    typedef logic [WarpWidth-1:0]   act_mask_t;
    typedef logic [RegWidth-1:0]    data_t;

endpackage

/* gpu_inst_pkg.sv */
// Instruction and register access records
// Dispatch, register read, register write and issue structs

package gpu_inst_pkg;

    import gpu_cfg_pkg::*;

    // Instruction as handed in by the dispatcher
    typedef struct packed {
        iid_t      iid;
        pc_t       pc;
        act_mask_t act_mask;
        reg_idx_t  dst;
        // Source register indices, slot 0 in the low bits
        reg_idx_t [OperandsPerInst-1:0] src;
    } disp_inst_t;

    // One register read on a single operand port
    typedef struct packed {
        wid_t     wid;
        reg_idx_t idx;
    } rf_read_req_t;

    // Register update through the write port
    typedef struct packed {
        wid_t     wid;
        reg_idx_t idx;
        data_t    data;
    } rf_write_t;

    // Instruction with its operands, toward the execution unit
    typedef struct packed {
        iid_t      iid;
        pc_t       pc;
        act_mask_t act_mask;
        reg_idx_t  dst;
        data_t [OperandsPerInst-1:0] opnd;
    } issue_inst_t;

endpackage

/* opc_cluster_top.sv */
// Operand collection cluster
// Router, collectors, read arbiter, register file and issue arbiter

`timescale 1ns/100ps

module opc_cluster_top
    import gpu_cfg_pkg::*, gpu_inst_pkg::*;
#(
    parameter int unsigned NumCollectors = 4
) (
    input  logic clk_i,
    input  logic arst_n_i,

    // Dispatcher
    input  logic        disp_valid_i,
    input  disp_inst_t  disp_inst_i,
    output logic        disp_ready_o,

    // Register loads
    input  logic        wr_en_i,
    input  rf_write_t   wr_i,

    // Execution unit
    output logic        eu_valid_o,
    output issue_inst_t eu_inst_o,
    input  logic        eu_ready_i
);

    // ####################
    // Interconnect
    // ####################

    // Router to collectors
    logic [NumCollectors-1:0] col_in_valid;
    logic [NumCollectors-1:0] col_in_ready;

    // Collectors to read arbiter
    logic         [NumCollectors-1:0][OperandsPerInst-1:0] rd_req_valid;
    rf_read_req_t [NumCollectors-1:0][OperandsPerInst-1:0] rd_req;
    logic         [NumCollectors-1:0][OperandsPerInst-1:0] rd_req_ready;
    logic         [NumCollectors-1:0][OperandsPerInst-1:0] rd_rsp_valid;
    data_t        [OperandsPerInst-1:0]                    rd_rsp_data;

    // Read arbiter to register file
    logic         [OperandsPerInst-1:0] rf_rd_en;
    rf_read_req_t [OperandsPerInst-1:0] rf_rd;
    data_t        [OperandsPerInst-1:0] rf_rd_data;

    // Collectors to issue arbiter
    logic        [NumCollectors-1:0] col_issue_valid;
    issue_inst_t [NumCollectors-1:0] col_issue_inst;
    logic        [NumCollectors-1:0] col_issue_ready;

    // ####################
    // Instances
    // ####################

    opc_dispatch_router #(
        .NumCollectors(NumCollectors)
    ) u_router (
        .disp_valid_i(disp_valid_i),
        .disp_ready_o(disp_ready_o),
        .col_ready_i (col_in_ready),
        .col_valid_o (col_in_valid)
    );

    // Instruction bus goes to every collector
    for (genvar c = 0; c < NumCollectors; c++) begin : g_col
        operand_collector u_col (
            .clk_i         (clk_i),
            .arst_n_i      (arst_n_i),
            .in_valid_i    (col_in_valid[c]),
            .in_inst_i     (disp_inst_i),
            .ready_o       (col_in_ready[c]),
            .rd_req_valid_o(rd_req_valid[c]),
            .rd_req_o      (rd_req[c]),
            .rd_req_ready_i(rd_req_ready[c]),
            .rd_rsp_valid_i(rd_rsp_valid[c]),
            .rd_rsp_data_i (rd_rsp_data),
            .issue_valid_o (col_issue_valid[c]),
            .issue_inst_o  (col_issue_inst[c]),
            .issue_ready_i (col_issue_ready[c])
        );
    end

    rf_read_arbiter #(
        .NumCollectors(NumCollectors)
    ) u_rd_arb (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_valid_i (rd_req_valid),
        .req_i       (rd_req),
        .req_ready_o (rd_req_ready),
        .rf_rd_en_o  (rf_rd_en),
        .rf_rd_o     (rf_rd),
        .rf_rd_data_i(rf_rd_data),
        .rsp_valid_o (rd_rsp_valid),
        .rsp_data_o  (rd_rsp_data)
    );

    register_file u_rf (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .rd_en_i  (rf_rd_en),
        .rd_i     (rf_rd),
        .rd_data_o(rf_rd_data),
        .wr_en_i  (wr_en_i),
        .wr_i     (wr_i)
    );

    eu_issue_arbiter #(
        .NumCollectors(NumCollectors)
    ) u_issue_arb (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .col_valid_i(col_issue_valid),
        .col_inst_i (col_issue_inst),
        .col_ready_o(col_issue_ready),
        .eu_valid_o (eu_valid_o),
        .eu_inst_o  (eu_inst_o),
        .eu_ready_i (eu_ready_i)
    );

endmodule

/* opc_dispatch_router.sv */
// Dispatch router for the operand collectors
// Steers each instruction to the lowest-index free collector

`timescale 1ns/100ps

module opc_dispatch_router #(
    parameter int unsigned NumCollectors = 4
) (
    // Dispatcher handshake
    input  logic                     disp_valid_i,
    output logic                     disp_ready_o,

    // Per collector levels and strobes
    input  logic [NumCollectors-1:0] col_ready_i,
    output logic [NumCollectors-1:0] col_valid_o
);

    // Any free collector accepts
    assign disp_ready_o = |col_ready_i;

    // Priority search from collector 0 upward
    always_comb begin
        logic taken;
        taken       = 1'b0;
        col_valid_o = '0;
        for (int c = 0; c < NumCollectors; c++) begin
            if (!taken && col_ready_i[c]) begin
                // Only the first free one sees the strobe
                col_valid_o[c] = disp_valid_i;
                taken          = 1'b1;
            end
        end
    end

endmodule

/* operand_collector.sv */
// Operand collector slot
// Holds one instruction and gathers its source operands

`timescale 1ns/100ps

module operand_collector
    import gpu_cfg_pkg::*, gpu_inst_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,

    // From the dispatch router
    input  logic       in_valid_i,
    input  disp_inst_t in_inst_i,
    output logic       ready_o,

    // Read requests toward the read arbiter
    output logic         [OperandsPerInst-1:0] rd_req_valid_o,
    output rf_read_req_t [OperandsPerInst-1:0] rd_req_o,
    input  logic         [OperandsPerInst-1:0] rd_req_ready_i,

    // Read responses, one cycle after the grant
    input  logic  [OperandsPerInst-1:0] rd_rsp_valid_i,
    input  data_t [OperandsPerInst-1:0] rd_rsp_data_i,

    // Toward the issue arbiter
    output logic        issue_valid_o,
    output issue_inst_t issue_inst_o,
    input  logic        issue_ready_i
);

    // ####################
    // State
    // ####################

    // Slot holds a live instruction
    logic occupied_q;
    // Read granted per operand
    logic [OperandsPerInst-1:0] requested_q;
    // Data received per operand
    logic [OperandsPerInst-1:0] opnd_ready_q;
    // Latched instruction fields
    disp_inst_t inst_q;
    // Gathered operand values
    data_t [OperandsPerInst-1:0] opnd_data_q;

    // Handshake strobes
    logic accept;
    logic issue_fire;

    // Free slot takes the next instruction
    assign ready_o    = !occupied_q;
    assign accept     = in_valid_i && ready_o;
    assign issue_fire = issue_valid_o && issue_ready_i;

    // ####################
    // Read requests
    // ####################

    // Request each operand until the arbiter grants it
    always_comb begin
        for (int s = 0; s < OperandsPerInst; s++) begin
            rd_req_valid_o[s] = occupied_q && !requested_q[s];
            // Warp id sits in the low bits of the iid
            rd_req_o[s].wid   = inst_q.iid[WidWidth-1:0];
            rd_req_o[s].idx   = inst_q.src[s];
        end
    end

    // Occupancy and per operand flags
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            occupied_q   <= 1'b0;
            requested_q  <= '0;
            opnd_ready_q <= '0;
        end else if (accept) begin
            // Fresh instruction starts with nothing requested
            occupied_q   <= 1'b1;
            requested_q  <= '0;
            opnd_ready_q <= '0;
        end else begin
            if (issue_fire) begin
                occupied_q <= 1'b0;
            end
            for (int s = 0; s < OperandsPerInst; s++) begin
                if (rd_req_valid_o[s] && rd_req_ready_i[s]) begin
                    requested_q[s] <= 1'b1;
                end
                if (rd_rsp_valid_i[s]) begin
                    opnd_ready_q[s] <= 1'b1;
                end
            end
        end
    end

    // Instruction fields and operand data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q <= in_inst_i;
        end
        for (int s = 0; s < OperandsPerInst; s++) begin
            if (rd_rsp_valid_i[s]) begin
                opnd_data_q[s] <= rd_rsp_data_i[s];
            end
        end
    end

    // ####################
    // Issue
    // ####################

    // Valid once every operand is in
    assign issue_valid_o = occupied_q && (&opnd_ready_q);

    always_comb begin
        issue_inst_o.iid      = inst_q.iid;
        issue_inst_o.pc       = inst_q.pc;
        issue_inst_o.act_mask = inst_q.act_mask;
        issue_inst_o.dst      = inst_q.dst;
        issue_inst_o.opnd     = opnd_data_q;
    end

endmodule

/* register_file.sv */
// Per-warp register file
// One registered read port per operand slot and one write port

`timescale 1ns/100ps

module register_file
    import gpu_cfg_pkg::*, gpu_inst_pkg::*;
(
    input  logic clk_i,
    input  logic arst_n_i,

    // Read ports, one per operand slot
    input  logic         [OperandsPerInst-1:0] rd_en_i,
    input  rf_read_req_t [OperandsPerInst-1:0] rd_i,
    output data_t        [OperandsPerInst-1:0] rd_data_o,

    // Write port for register loads
    input  logic      wr_en_i,
    input  rf_write_t wr_i
);

    // Storage by warp then register
    data_t mem_q [NumWarps][NumRegs];

    // Read data, one cycle after the enable
    data_t [OperandsPerInst-1:0] rd_data_q;

    // ####################
    // Write
    // ####################

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_i.wid][wr_i.idx] <= wr_i.data;
        end
    end

    // ####################
    // Read
    // ####################

    // Same-cycle write is not forwarded
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_data_q <= '0;
        end else begin
            for (int s = 0; s < OperandsPerInst; s++) begin
                if (rd_en_i[s]) begin
                    rd_data_q[s] <= mem_q[rd_i[s].wid][rd_i[s].idx];
                end
            end
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

/* rf_read_arbiter.sv */
// Register read arbiter
// Round-robin grant per operand port and routing of read data back

`timescale 1ns/100ps

module rf_read_arbiter
    import gpu_cfg_pkg::*, gpu_inst_pkg::*;
#(
    parameter int unsigned NumCollectors = 4
) (
    input  logic clk_i,
    input  logic arst_n_i,

    // Collector requests, indexed by collector then slot
    input  logic         [NumCollectors-1:0][OperandsPerInst-1:0] req_valid_i,
    input  rf_read_req_t [NumCollectors-1:0][OperandsPerInst-1:0] req_i,
    output logic         [NumCollectors-1:0][OperandsPerInst-1:0] req_ready_o,

    // Register file read ports
    output logic         [OperandsPerInst-1:0] rf_rd_en_o,
    output rf_read_req_t [OperandsPerInst-1:0] rf_rd_o,
    input  data_t        [OperandsPerInst-1:0] rf_rd_data_i,

    // Responses, data shared and valid per collector
    output logic  [NumCollectors-1:0][OperandsPerInst-1:0] rsp_valid_o,
    output data_t [OperandsPerInst-1:0]                    rsp_data_o
);

    localparam int unsigned IdxWidth = (NumCollectors > 1) ? $clog2(NumCollectors) : 1;
    typedef logic [IdxWidth-1:0] col_idx_t;

    // Round-robin pointer per slot
    col_idx_t [OperandsPerInst-1:0] ptr_q;
    col_idx_t [OperandsPerInst-1:0] ptr_d;
    // Current winner per slot
    col_idx_t [OperandsPerInst-1:0] win;
    logic     [OperandsPerInst-1:0] found;
    // Winner of last cycle, waiting for its data
    col_idx_t [OperandsPerInst-1:0] win_q;
    logic     [OperandsPerInst-1:0] pend_q;

    // ####################
    // Grant
    // ####################

    always_comb begin
        col_idx_t cand;
        found       = '0;
        win         = '0;
        req_ready_o = '0;
        for (int s = 0; s < OperandsPerInst; s++) begin
            // Search starts at the pointer and wraps
            for (int k = 0; k < NumCollectors; k++) begin
                cand = col_idx_t'((int'(ptr_q[s]) + k) % NumCollectors);
                if (!found[s] && req_valid_i[cand][s]) begin
                    found[s] = 1'b1;
                    win[s]   = cand;
                end
            end
            req_ready_o[win[s]][s] = found[s];
            rf_rd_en_o[s]          = found[s];
            rf_rd_o[s]             = req_i[win[s]][s];
            // Pointer moves one past the winner
            ptr_d[s] = found[s] ? col_idx_t'((int'(win[s]) + 1) % NumCollectors) : ptr_q[s];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr_q  <= '0;
            win_q  <= '0;
            pend_q <= '0;
        end else begin
            ptr_q  <= ptr_d;
            win_q  <= win;
            pend_q <= found;
        end
    end

    // ####################
    // Response
    // ####################

    // Data arrives one cycle after the grant
    always_comb begin
        for (int c = 0; c < NumCollectors; c++) begin
            for (int s = 0; s < OperandsPerInst; s++) begin
                rsp_valid_o[c][s] = pend_q[s] && (win_q[s] == col_idx_t'(c));
            end
        end
    end

    assign rsp_data_o = rf_rd_data_i;

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the operand collector testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_opc_cluster \
    -f files.f

./obj_dir/Vtb_opc_cluster > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
else
    exit 1
fi

/* tb_opc_cluster.sv */
// Testbench for the operand collection cluster
// Register preload, instruction table, random back-pressure and scoreboard

`timescale 1ns/100ps

module tb_opc_cluster
    import gpu_cfg_pkg::*, gpu_inst_pkg::*;
();

    localparam int NumCol    = 4;
    localparam int NumStim   = 12;
    localparam int NumIids   = 1 << $bits(iid_t);
    localparam int WaitLimit = 200;

    // Back-pressure modes
    localparam int BpHigh   = 0;
    localparam int BpLow    = 1;
    localparam int BpRandom = 2;

    // One table row, sources split out for readability
    typedef struct packed {
        iid_t      iid;
        pc_t       pc;
        act_mask_t mask;
        reg_idx_t  dst;
        reg_idx_t  src0;
        reg_idx_t  src1;
    } stim_t;

    // ####################
    // Stimulus table
    // ####################

    // iid is {tag, warp}, every entry unique
    stim_t stim_tab [NumStim] = '{
        '{5'h00, 32'h0000_1000, 8'hFF, 4'd1,  4'd2,  4'd3},
        '{5'h01, 32'h0000_1004, 8'h0F, 4'd4,  4'd5,  4'd6},
        '{5'h02, 32'h0000_1008, 8'hF0, 4'd7,  4'd0,  4'd15},
        '{5'h03, 32'h0000_100C, 8'hAA, 4'd2,  4'd9,  4'd9},
        '{5'h04, 32'h0000_1010, 8'h55, 4'd3,  4'd14, 4'd1},
        '{5'h05, 32'h0000_1014, 8'h81, 4'd8,  4'd11, 4'd12},
        '{5'h06, 32'h0000_1018, 8'h7E, 4'd0,  4'd3,  4'd8},
        '{5'h07, 32'h0000_101C, 8'hC3, 4'd15, 4'd6,  4'd10},
        '{5'h08, 32'h0000_2000, 8'h01, 4'd5,  4'd13, 4'd4},
        '{5'h0A, 32'h0000_2004, 8'h80, 4'd6,  4'd1,  4'd7},
        '{5'h13, 32'h0000_3000, 8'h3C, 4'd9,  4'd12, 4'd0},
        '{5'h1F, 32'h0000_4000, 8'hE7, 4'd10, 4'd15, 4'd14}
    };

    // Reads the register rewritten in the last test
    localparam stim_t RewriteRow = '{5'h0D, 32'h0000_5000, 8'h3C, 4'd7, 4'd7, 4'd9};

    // DUT ports
    logic        clk_i;
    logic        arst_n_i;
    logic        disp_valid_i;
    disp_inst_t  disp_inst_i;
    logic        disp_ready_o;
    logic        wr_en_i;
    rf_write_t   wr_i;
    logic        eu_valid_o;
    issue_inst_t eu_inst_o;
    logic        eu_ready_i;

    // Reference register contents
    data_t ref_regs [NumWarps][NumRegs];

    // Scoreboard keyed by iid
    issue_inst_t exp_inst [NumIids];
    logic        pending  [NumIids];
    int          outstanding;

    int     errors;
    int     err_mark;
    int     tests_run;
    int     tests_failed;
    int     bp_mode;
    int     cycle_cnt;
    int     disp_cycle;
    int     issue_cycle;
    integer seed;

    // Monitor state for the stall check
    logic        stall_q;
    issue_inst_t held_inst;

    opc_cluster_top #(
        .NumCollectors(NumCol)
    ) dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .disp_valid_i(disp_valid_i),
        .disp_inst_i (disp_inst_i),
        .disp_ready_o(disp_ready_o),
        .wr_en_i     (wr_en_i),
        .wr_i        (wr_i),
        .eu_valid_o  (eu_valid_o),
        .eu_inst_o   (eu_inst_o),
        .eu_ready_i  (eu_ready_i)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Cycle counter and execution unit ready, both on the falling edge
    initial begin
        logic [31:0] rnd;
        cycle_cnt  = 0;
        eu_ready_i = 1'b1;
        forever begin
            @(negedge clk_i);
            cycle_cnt = cycle_cnt + 1;
            case (bp_mode)
                BpHigh:  eu_ready_i = 1'b1;
                BpLow:   eu_ready_i = 1'b0;
                default: begin
                    rnd        = $random(seed);
                    eu_ready_i = rnd[0];
                end
            endcase
        end
    end

    // ####################
    // Helpers
    // ####################

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            $display("MISMATCH %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    function automatic disp_inst_t to_disp(input stim_t row);
        disp_inst_t d;
        d.iid      = row.iid;
        d.pc       = row.pc;
        d.act_mask = row.mask;
        d.dst      = row.dst;
        d.src[0]   = row.src0;
        d.src[1]   = row.src1;
        return d;
    endfunction

    // Operands come from the reference registers of the row's warp
    function automatic issue_inst_t expected_issue(input stim_t row);
        issue_inst_t e;
        wid_t        w;
        w          = row.iid[WidWidth-1:0];
        e.iid      = row.iid;
        e.pc       = row.pc;
        e.act_mask = row.mask;
        e.dst      = row.dst;
        e.opnd[0]  = ref_regs[w][row.src0];
        e.opnd[1]  = ref_regs[w][row.src1];
        return e;
    endfunction

    // Scoreboard update on an execution unit handshake
    task automatic record_issue(input issue_inst_t got);
        issue_inst_t exp;
        assert (pending[got.iid]) else begin
            $display("Instruction %h issued without a dispatch or more than once", got.iid);
            errors++;
        end
        if (pending[got.iid]) begin
            exp = exp_inst[got.iid];
            compare_field("eu_inst_o.pc", got.pc, exp.pc);
            compare_field("eu_inst_o.act_mask", 32'(got.act_mask), 32'(exp.act_mask));
            compare_field("eu_inst_o.dst", 32'(got.dst), 32'(exp.dst));
            compare_field("eu_inst_o.opnd[0]", got.opnd[0], exp.opnd[0]);
            compare_field("eu_inst_o.opnd[1]", got.opnd[1], exp.opnd[1]);
            pending[got.iid] = 1'b0;
            outstanding--;
            issue_cycle = cycle_cnt;
        end
    endtask

    // Issue monitor, samples on the rising edge
    initial begin
        stall_q   = 1'b0;
        held_inst = '0;
        forever begin
            @(posedge clk_i);
            if (arst_n_i) begin
                if (stall_q) begin
                    assert (eu_valid_o && eu_inst_o == held_inst) else begin
                        $display("MISMATCH eu_inst_o under stall: expected %h, got %h",
                                 held_inst, eu_inst_o);
                        errors++;
                    end
                end
                if (eu_valid_o && eu_ready_i) begin
                    record_issue(eu_inst_o);
                end
                stall_q   = eu_valid_o && !eu_ready_i;
                held_inst = eu_inst_o;
            end
        end
    end

    // Entered on a falling edge, leaves on a falling edge
    task automatic write_reg(input wid_t w, input reg_idx_t r, input data_t d);
        wr_en_i        = 1'b1;
        wr_i           = '{w, r, d};
        ref_regs[w][r] = d;
        @(negedge clk_i);
        wr_en_i = 1'b0;
    endtask

    // Every register gets A000_0000 + warp*256 + index
    task automatic preload_regs();
        for (int w = 0; w < NumWarps; w++) begin
            for (int r = 0; r < NumRegs; r++) begin
                write_reg(wid_t'(w), reg_idx_t'(r), 32'hA000_0000 + 32'(w) * 256 + 32'(r));
            end
        end
    endtask

    // Holds valid until the handshake, then drops it on the next falling edge
    task automatic dispatch(input stim_t row);
        int waited;
        waited            = 0;
        exp_inst[row.iid] = expected_issue(row);
        pending[row.iid]  = 1'b1;
        outstanding++;
        disp_valid_i = 1'b1;
        disp_inst_i  = to_disp(row);
        do begin
            @(posedge clk_i);
            waited++;
        end while (!disp_ready_o && waited < WaitLimit);
        assert (disp_ready_o) else begin
            $display("Timeout waiting for disp_ready_o with instruction %h", row.iid);
            errors++;
            pending[row.iid] = 1'b0;
            outstanding--;
        end
        disp_cycle = cycle_cnt;
        @(negedge clk_i);
        disp_valid_i = 1'b0;
    endtask

    // Waits until every dispatched instruction has issued
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (outstanding > 0 && waited < WaitLimit) begin
            @(negedge clk_i);
            waited++;
        end
        assert (outstanding == 0) else begin
            $display("Timeout with %0d instructions never issued", outstanding);
            errors++;
            outstanding = 0;
            for (int i = 0; i < NumIids; i++) begin
                pending[i] = 1'b0;
            end
        end
    endtask

    // Mode changes on a rising edge so the driver sees it cleanly
    task automatic set_backpressure(input int mode);
        @(posedge clk_i);
        bp_mode = mode;
        @(negedge clk_i);
    endtask

    task automatic start_test();
        err_mark = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL with %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    // ####################
    // Test sequence
    // ####################

    initial begin
        arst_n_i     = 1'b0;
        disp_valid_i = 1'b0;
        disp_inst_i  = '0;
        wr_en_i      = 1'b0;
        wr_i         = '0;
        seed         = 32'h2b8b_79ac;
        bp_mode      = BpHigh;
        outstanding  = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        disp_cycle   = 0;
        issue_cycle  = 0;
        for (int i = 0; i < NumIids; i++) begin
            pending[i] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // Idle outputs straight out of reset
        start_test();
        compare_field("disp_ready_o", 32'(disp_ready_o), 32'h1);
        compare_field("eu_valid_o", 32'(eu_valid_o), 32'h0);
        finish_test("reset state");

        preload_regs();

        // Lone instruction, no back-pressure
        start_test();
        dispatch(stim_tab[0]);
        wait_drain();
        assert (issue_cycle - disp_cycle >= 3 && issue_cycle - disp_cycle <= 10) else begin
            $display("Issue latency of %0d cycles is outside 3 to 10",
                     issue_cycle - disp_cycle);
            errors++;
        end
        finish_test("single instruction");

        // All collectors busy while the unit stalls
        start_test();
        set_backpressure(BpLow);
        for (int i = 1; i <= NumCol; i++) begin
            dispatch(stim_tab[i]);
        end
        compare_field("disp_ready_o", 32'(disp_ready_o), 32'h0);
        set_backpressure(BpHigh);
        wait_drain();
        finish_test("fill");

        // Whole table with random ready
        start_test();
        set_backpressure(BpRandom);
        for (int i = 0; i < NumStim; i++) begin
            dispatch(stim_tab[i]);
        end
        wait_drain();
        set_backpressure(BpHigh);
        finish_test("random stream");

        // New register value must reach the operand
        start_test();
        write_reg(3'd5, 4'd7, 32'h1234_5678);
        dispatch(RewriteRow);
        wait_drain();
        finish_test("write then read");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
